// File: Makefile
TOP = icache_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns -j 0 --top-module $(TOP) -f sim.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

// File: sim.f
verilog/icache_pkg.sv
verilog/icache_tag_store.sv
verilog/icache_data_store.sv
verilog/icache_refill.sv
verilog/icache_lookup.sv
verilog/icache_top.sv
test/tb_clock.sv
test/sdram_model.sv
test/icache_tb.sv

// File: test/icache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module icache_tb;
    import icache_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int SEED            = 86160;
    localparam int REQ_LIMIT       = 200;  // Cycles allowed per request
    localparam int MIX_COUNT       = 300;
    localparam int NUM_REQUESTS    = 25 + MIX_COUNT;
    localparam int NUM_TESTS       = 6;
    localparam int WATCHDOG_CYCLES = NUM_REQUESTS * REQ_LIMIT + 20;

    logic  Clk;
    logic  rst;
    logic  read_enable;
    addr_t read_address;
    word_t instruction;
    logic  ready;
    logic  busy;
    addr_t mem_read_address;
    logic  mem_read_request;
    word_t mem_data_in;
    logic  mem_data_ready;
    int    start_wait_max;
    int    gap_max;

    // Reference tag state, invalid first then round robin
    tag_t     model_tag   [NUM_SETS][NUM_WAYS];
    logic     model_valid [NUM_SETS][NUM_WAYS];
    way_idx_t model_rr    [NUM_SETS];

    int    errors;
    int    checks;
    int    monitor_errors;
    int    req_count;
    addr_t req_addr;  // Address seen when the request rose
    logic  req_prev;

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) u_clock (.Clk(Clk));

    sdram_model u_sdram (
        .Clk            (Clk),
        .address        (mem_read_address),
        .request        (mem_read_request),
        .data           (mem_data_in),
        .data_ready     (mem_data_ready),
        .start_wait_max (start_wait_max),
        .gap_max        (gap_max)
    );

    icache_top u_icache_top (
        .Clk              (Clk),
        .rst              (rst),
        .read_enable      (read_enable),
        .read_address     (read_address),
        .instruction      (instruction),
        .ready            (ready),
        .busy             (busy),
        .mem_read_address (mem_read_address),
        .mem_read_request (mem_read_request),
        .mem_data_in      (mem_data_in),
        .mem_data_ready   (mem_data_ready)
    );

    function automatic word_t rule_word(addr_t a);
        return {a[31:2], 2'b00} ^ 32'h5A5A_0000;
    endfunction

    function automatic int total_errors();
        return errors + monitor_errors;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s: got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERROR t=%0t %s: got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    function automatic way_idx_t model_victim(set_idx_t s);
        way_idx_t v;
        v = model_rr[s];
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!model_valid[s][w]) begin
                v = way_idx_t'(w);
            end
        end
        return v;
    endfunction

    // Predicts hit or miss and updates the reference tags
    task automatic model_access(input addr_t a, output logic miss);
        set_idx_t s;
        tag_t     t;
        way_idx_t v;
        logic     full;
        s    = a[OFFSET_BITS +: SET_BITS];
        t    = a[31 -: TAG_BITS];
        miss = 1'b1;
        full = 1'b1;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (model_valid[s][w] && (model_tag[s][w] == t)) begin
                miss = 1'b0;
            end
            full = full & model_valid[s][w];
        end
        if (miss) begin
            v = model_victim(s);
            if (full) begin
                model_rr[s] = model_rr[s] + 1'b1;
            end
            model_tag[s][v]   = t;
            model_valid[s][v] = 1'b1;
        end
    endtask

    // Starts and ends on a falling edge
    task automatic issue_read(input addr_t a, input logic hold, output word_t word,
                              output logic miss, output int cycles);
        int   req_before;
        logic got;
        req_before = req_count;
        got        = 1'b0;
        cycles     = 0;
        word       = '0;
        check_flag("busy", busy, 1'b0);
        read_enable  = 1'b1;
        read_address = a;
        while (!got && (cycles < REQ_LIMIT)) begin
            @(negedge Clk);
            cycles++;
            read_address = $urandom();  // Captured already
            if (!hold) begin
                read_enable = 1'b0;
            end
            if (ready) begin
                got         = 1'b1;
                word        = instruction;
                read_enable = 1'b0;
            end else if (!busy) begin
                errors++;
                $display("Busy went low before ready for address %h at %0t", a, $time);
            end
        end
        if (!got) begin
            errors++;
            $display("No ready within %0d cycles for address %h, lookup FSM in %s",
                     REQ_LIMIT, a, u_icache_top.u_lookup.state.name());
        end
        miss = (req_count != req_before);
    endtask

    task automatic read_and_compare(input addr_t a, input logic hold, output logic miss,
                                    output int cycles);
        logic  exp_miss;
        int    req_before;
        word_t word;
        model_access(a, exp_miss);
        req_before = req_count;
        issue_read(a, hold, word, miss, cycles);
        check_word("instruction", word, rule_word(a));
        check_flag("mem_read_request (miss)", miss, exp_miss);
        if (miss) begin
            check_count("memory requests", req_count - req_before, 1);
            check_addr("mem_read_address", req_addr, {a[31:OFFSET_BITS], 4'h0});
        end
    endtask

    // No stray response or request after a finished one, last word stays put
    task automatic expect_quiet(input int n, input word_t last);
        int req_before;
        req_before = req_count;
        repeat (n) begin
            @(negedge Clk);
            check_flag("ready", ready, 1'b0);
            check_flag("busy", busy, 1'b0);
            check_word("instruction (held)", instruction, last);
        end
        check_count("memory requests", req_count - req_before, 0);
    endtask

    task automatic finish_test(input int num, input string name, input int start);
        $display("Test %0d %s: %0d errors", num, name, total_errors() - start);
    endtask

    task automatic test_cold_read();
        int   start;
        logic miss;
        int   cycles;
        start = total_errors();
        check_flag("ready", ready, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_flag("mem_read_request", mem_read_request, 1'b0);
        read_and_compare(32'h0000_1234, 1'b0, miss, cycles);
        check_flag("mem_read_request (miss)", miss, 1'b1);
        finish_test(1, "cold read", start);
    endtask

    task automatic test_block_hits();
        int   start;
        logic miss;
        int   cycles;
        start = total_errors();
        for (int w = 0; w < BLOCK_WORDS; w++) begin
            read_and_compare(32'h0000_1230 + addr_t'(w * WORD_BYTES), 1'b0, miss, cycles);
            check_flag("mem_read_request (miss)", miss, 1'b0);
            check_count("cycles to ready", cycles, 3);
        end
        finish_test(2, "hits in a filled block", start);
    endtask

    task automatic test_fill_one_set();
        int       start;
        logic     miss;
        int       cycles;
        way_idx_t victim;
        addr_t    evicted;
        start = total_errors();
        // Tags 512 and up, all in set 5
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < NUM_WAYS; i++) begin
                read_and_compare({tag_t'(512 + i), set_idx_t'(5), 4'h8}, 1'b0, miss, cycles);
                check_flag("mem_read_request (miss)", miss, (pass == 0));
            end
        end
        victim  = model_victim(set_idx_t'(5));
        evicted = {model_tag[5][victim], set_idx_t'(5), 4'h8};
        read_and_compare({tag_t'(512 + NUM_WAYS), set_idx_t'(5), 4'h8}, 1'b0, miss, cycles);
        check_flag("mem_read_request (miss)", miss, 1'b1);
        read_and_compare(evicted, 1'b0, miss, cycles);
        check_flag("mem_read_request (evicted block)", miss, 1'b1);
        finish_test(3, "replacement in one set", start);
    endtask

    task automatic test_random_timing();
        int   start;
        logic miss;
        int   cycles;
        start          = total_errors();
        start_wait_max = 12;
        gap_max        = 5;
        for (int i = 0; i < 8; i++) begin
            read_and_compare(32'h0002_0000 + addr_t'(i * 20), 1'b0, miss, cycles);
            check_flag("mem_read_request (miss)", miss, 1'b1);
        end
        finish_test(4, "misses with random memory timing", start);
    endtask

    task automatic test_random_mix();
        int    start;
        logic  miss;
        int    cycles;
        int    misses;
        addr_t a;
        start          = total_errors();
        misses         = 0;
        start_wait_max = 4;
        gap_max        = 2;
        // 1 KB region, so every set sees eviction
        for (int i = 0; i < MIX_COUNT; i++) begin
            a = 32'h0000_8000 + ($urandom_range(255) << 2);
            read_and_compare(a, 1'b0, miss, cycles);
            if (miss) begin
                misses++;
            end
        end
        finish_test(5, $sformatf("random mix (%0d hits, %0d misses)",
                                 MIX_COUNT - misses, misses), start);
    endtask

    task automatic test_held_enable();
        int   start;
        logic miss;
        int   cycles;
        start = total_errors();
        read_and_compare(32'h0000_123C, 1'b1, miss, cycles);
        expect_quiet(6, rule_word(32'h0000_123C));
        read_and_compare(32'h0003_0040, 1'b1, miss, cycles);
        expect_quiet(6, rule_word(32'h0003_0040));
        finish_test(6, "read_enable held while busy", start);
    endtask

    // Memory request monitor, checks the address holds for the whole burst
    initial begin
        req_count      = 0;
        monitor_errors = 0;
        req_addr       = '0;
        req_prev       = 1'b0;
        forever begin
            @(negedge Clk);
            if (mem_read_request === 1'b1 && !req_prev) begin
                req_count++;
                req_addr = mem_read_address;
            end else if (mem_read_request === 1'b1 && (mem_read_address !== req_addr)) begin
                monitor_errors++;
                $display("ERROR t=%0t mem_read_address: got %h expected %h",
                         $time, mem_read_address, req_addr);
            end
            req_prev = (mem_read_request === 1'b1);
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run went past %0d cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        errors         = 0;
        checks         = 0;
        rst            = 1'b1;
        read_enable    = 1'b0;
        read_address   = '0;
        start_wait_max = 0;
        gap_max        = 0;
        for (int s = 0; s < NUM_SETS; s++) begin
            model_rr[s] = '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                model_valid[s][w] = 1'b0;
                model_tag[s][w]   = '0;
            end
        end
        repeat (4) @(negedge Clk);
        rst = 1'b0;

        test_cold_read();
        test_block_hits();
        test_fill_one_set();
        test_random_timing();
        test_random_mix();
        test_held_enable();

        $display("Done: %0d tests, %0d checks, %0d errors", NUM_TESTS, checks, total_errors());
        if (total_errors() == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/sdram_model.sv
`timescale 1ns/1ns
`default_nettype none

module sdram_model (
    input  logic              Clk,
    input  icache_pkg::addr_t address,
    input  logic              request,
    output icache_pkg::word_t data,
    output logic              data_ready,
    input  int                start_wait_max,  // Cycles before the first beat, at most
    input  int                gap_max          // Idle cycles between beats, at most
);
    import icache_pkg::*;

    addr_t base;
    int    wait_cycles;

    // Outputs change on the falling edge only
    initial begin
        data       = '0;
        data_ready = 1'b0;
        forever begin
            @(negedge Clk);
            if (request) begin
                base = address;
                for (int b = 0; b < BLOCK_WORDS; b++) begin
                    if (b == 0) begin
                        wait_cycles = $urandom_range(start_wait_max);
                    end else begin
                        wait_cycles = $urandom_range(gap_max);
                    end
                    repeat (wait_cycles) @(negedge Clk);
                    // Each word holds its own byte address, scrambled
                    data       = (base + addr_t'(b * WORD_BYTES)) ^ 32'h5A5A_0000;
                    data_ready = 1'b1;
                    @(negedge Clk);
                    data_ready = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: test/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic Clk
);

    // Free running, starts low
    initial begin
        Clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) Clk = ~Clk;
        end
    end

endmodule

`default_nettype wire

// File: verilog/icache_data_store.sv
`timescale 1ns/1ns
`default_nettype none

module icache_data_store (
    input  logic                 Clk,
    input  icache_pkg::set_idx_t rd_set,
    input  icache_pkg::way_idx_t rd_way,
    output icache_pkg::block_t   rd_block,
    input  logic                 wr_en,
    input  icache_pkg::set_idx_t wr_set,
    input  icache_pkg::way_idx_t wr_way,
    input  icache_pkg::block_t   wr_block
);
    import icache_pkg::*;

    // One whole block per set and way
    block_t blocks [NUM_SETS][NUM_WAYS];

    // Block-wide fill from the refill engine
    always_ff @(posedge Clk) begin
        if (wr_en) begin
            blocks[wr_set][wr_way] <= wr_block;
        end
    end

    // Registered read, old contents on a same-cycle write
    always_ff @(posedge Clk) begin
        rd_block <= blocks[rd_set][rd_way];
    end

endmodule

`default_nettype wire

// File: verilog/icache_lookup.sv
`timescale 1ns/1ns
`default_nettype none

module icache_lookup (
    input  logic                 Clk,
    input  logic                 rst,
    input  logic                 read_enable,
    input  icache_pkg::addr_t    read_address,
    output icache_pkg::word_t    instruction,
    output logic                 ready,
    output logic                 busy,
    output icache_pkg::set_idx_t lookup_set,
    output icache_pkg::tag_t     lookup_tag,
    input  logic                 hit,
    input  icache_pkg::way_idx_t hit_way,
    input  icache_pkg::way_idx_t victim_way,
    output logic                 fill_en,
    output icache_pkg::set_idx_t fill_set,
    output icache_pkg::way_idx_t fill_way,
    output icache_pkg::tag_t     fill_tag,
    output icache_pkg::set_idx_t rd_set,
    output icache_pkg::way_idx_t rd_way,
    input  icache_pkg::block_t   rd_block,
    output logic                 wr_en,
    output icache_pkg::set_idx_t wr_set,
    output icache_pkg::way_idx_t wr_way,
    output icache_pkg::block_t   wr_block,
    output logic                 refill_start,
    output icache_pkg::addr_t    refill_address,
    input  logic                 refill_done,
    input  icache_pkg::block_t   refill_block
);
    import icache_pkg::*;

    lookup_state_t state;
    tag_t          tag_q;
    set_idx_t      set_q;
    word_off_t     off_q;
    way_idx_t      victim_q;
    logic          miss_q;    // Answer comes from the refill buffer
    word_t         hold_q;    // Last instruction, held between responses
    word_t         resp_word;
    logic          accept;

    assign accept = read_enable && !busy;

    assign lookup_set = set_q;
    assign lookup_tag = tag_q;
    assign rd_set     = set_q;
    assign rd_way     = hit_way;

    // Miss is known in READ, memory request follows one edge later
    assign refill_start   = (state == READ) && !hit;
    assign refill_address = {tag_q, set_q, {OFFSET_BITS{1'b0}}};

    // Tag and data written together at the latched victim
    assign fill_en  = (state == WAIT_FILL) && refill_done;
    assign fill_set = set_q;
    assign fill_way = victim_q;
    assign fill_tag = tag_q;
    assign wr_en    = fill_en;
    assign wr_set   = set_q;
    assign wr_way   = victim_q;
    assign wr_block = refill_block;

    assign resp_word = miss_q ? refill_block[off_q*$bits(word_t) +: $bits(word_t)]
                              : rd_block[off_q*$bits(word_t) +: $bits(word_t)];
    assign instruction = ready ? resp_word : hold_q;

    always_ff @(posedge Clk) begin
        if (rst) begin
            state  <= IDLE;
            ready  <= 1'b0;
            busy   <= 1'b0;
            miss_q <= 1'b0;
        end else begin
            ready <= 1'b0;
            case (state)
                IDLE, RESPOND: begin
                    if (accept) begin
                        state  <= COMPARE;
                        busy   <= 1'b1;
                        miss_q <= 1'b0;
                    end else begin
                        state <= IDLE;
                    end
                end
                COMPARE: state <= READ;  // Tag store registers its compare
                READ: begin
                    if (hit) begin
                        state <= RESPOND;
                        ready <= 1'b1;
                        busy  <= 1'b0;
                    end else begin
                        state  <= WAIT_FILL;
                        miss_q <= 1'b1;
                    end
                end
                WAIT_FILL: begin
                    if (refill_done) begin
                        state <= RESPOND;
                        ready <= 1'b1;
                        busy  <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (accept) begin
            tag_q <= read_address[31 -: TAG_BITS];
            set_q <= read_address[OFFSET_BITS +: SET_BITS];
            off_q <= read_address[$clog2(WORD_BYTES) +: $bits(word_off_t)];
        end
        if (refill_start) begin
            victim_q <= victim_way;
        end
        if (ready) begin
            hold_q <= resp_word;
        end
    end

    // A finished block is only expected while a miss waits for it
    a_done_in_wait: assert property (@(posedge Clk) disable iff (rst)
        refill_done |-> (state == WAIT_FILL));

endmodule

`default_nettype wire

// File: verilog/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // Cache geometry
    localparam int NUM_SETS    = 8;
    localparam int NUM_WAYS    = 4;
    localparam int BLOCK_WORDS = 4;
    localparam int WORD_BYTES  = 4;

    // Address split: tag | set | byte offset
    localparam int OFFSET_BITS = 4;
    localparam int SET_BITS    = 3;
    localparam int TAG_BITS    = 25;

    typedef logic [31:0]                   addr_t;
    typedef logic [WORD_BYTES*8-1:0]       word_t;
    typedef logic [TAG_BITS-1:0]           tag_t;
    typedef logic [SET_BITS-1:0]           set_idx_t;
    typedef logic [$clog2(NUM_WAYS)-1:0]    way_idx_t;
    typedef logic [$clog2(BLOCK_WORDS)-1:0] word_off_t;
    typedef logic [BLOCK_WORDS*WORD_BYTES*8-1:0] block_t;  // Word 0 in the low bits

    typedef enum logic [2:0] {
        IDLE,
        COMPARE,
        READ,
        WAIT_FILL,
        RESPOND
    } lookup_state_t;

    // Prefixed idle so it does not clash with the lookup FSM
    typedef enum logic [1:0] {
        REFILL_IDLE,
        FETCH,
        DONE
    } refill_state_t;

endpackage

`default_nettype wire

// File: verilog/icache_refill.sv
`timescale 1ns/1ns
`default_nettype none

module icache_refill (
    input  logic               Clk,
    input  logic               rst,
    input  logic               refill_start,
    input  icache_pkg::addr_t  refill_address,
    output logic               refill_done,
    output icache_pkg::block_t refill_block,
    output icache_pkg::addr_t  mem_read_address,
    output logic               mem_read_request,
    input  icache_pkg::word_t  mem_data_in,
    input  logic               mem_data_ready
);
    import icache_pkg::*;

    refill_state_t state;
    word_off_t     beat_cnt;
    logic          last_beat;

    assign last_beat   = mem_data_ready && (beat_cnt == word_off_t'(BLOCK_WORDS - 1));
    assign refill_done = (state == DONE);  // Block is complete for exactly one cycle

    always_ff @(posedge Clk) begin
        if (rst) begin
            state            <= REFILL_IDLE;
            mem_read_request <= 1'b0;
            beat_cnt         <= '0;
        end else begin
            case (state)
                REFILL_IDLE: begin
                    if (refill_start) begin
                        state            <= FETCH;
                        mem_read_request <= 1'b1;
                        beat_cnt         <= '0;
                    end
                end
                FETCH: begin
                    // Memory may stall between beats
                    if (mem_data_ready) begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                    if (last_beat) begin
                        mem_read_request <= 1'b0;
                        state            <= DONE;
                    end
                end
                DONE: begin
                    state <= REFILL_IDLE;
                end
                default: begin
                    state <= REFILL_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (refill_start && (state == REFILL_IDLE)) begin
            mem_read_address <= refill_address;  // Already block aligned
        end
        // Shift down so the first beat ends up as word 0
        if ((state == FETCH) && mem_data_ready) begin
            refill_block <= {mem_data_in, refill_block[$bits(block_t)-1:$bits(word_t)]};
        end
    end

    // Lookup must wait for the current block before asking again
    a_no_start_in_fetch: assert property (@(posedge Clk) disable iff (rst)
        refill_start |-> (state != FETCH));

    // Memory only ever sees whole-block bursts
    a_addr_aligned: assert property (@(posedge Clk) disable iff (rst)
        mem_read_request |-> (mem_read_address[OFFSET_BITS-1:0] == '0));

endmodule

`default_nettype wire

// File: verilog/icache_tag_store.sv
`timescale 1ns/1ns
`default_nettype none

module icache_tag_store (
    input  logic                 Clk,
    input  logic                 rst,
    input  icache_pkg::set_idx_t lookup_set,
    input  icache_pkg::tag_t     lookup_tag,
    output logic                 hit,
    output icache_pkg::way_idx_t hit_way,
    output icache_pkg::way_idx_t victim_way,
    input  logic                 fill_en,
    input  icache_pkg::set_idx_t fill_set,
    input  icache_pkg::way_idx_t fill_way,
    input  icache_pkg::tag_t     fill_tag
);
    import icache_pkg::*;

    tag_t                tags   [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid  [NUM_SETS];
    way_idx_t            rr_ptr [NUM_SETS];  // Next replacement per set

    logic [NUM_WAYS-1:0] set_valid;
    logic [NUM_WAYS-1:0] match;
    way_idx_t            match_way;
    way_idx_t            free_way;
    logic                any_free;

    // Compare every way of the selected set at once
    always_comb begin
        set_valid = valid[lookup_set];
        match_way = '0;
        free_way  = '0;
        any_free  = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            match[w] = set_valid[w] && (tags[lookup_set][w] == lookup_tag);
            if (match[w]) begin
                match_way = way_idx_t'(w);
            end
        end
        // Walk downwards so the lowest invalid way wins
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                free_way = way_idx_t'(w);
                any_free = 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            hit <= 1'b0;
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s]  <= '0;
                rr_ptr[s] <= '0;
            end
        end else begin
            hit <= |match;
            if (fill_en) begin
                valid[fill_set][fill_way] <= 1'b1;
                if (&valid[fill_set]) begin  // Full set, so the pointer picked this way
                    rr_ptr[fill_set] <= rr_ptr[fill_set] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        hit_way    <= match_way;
        victim_way <= any_free ? free_way : rr_ptr[lookup_set];
        if (fill_en) begin
            tags[fill_set][fill_way] <= fill_tag;
        end
    end

    // The controller only fills after a miss, so a line never lands twice in one set
    a_single_match: assert property (@(posedge Clk) disable iff (rst) $onehot0(match));

endmodule

`default_nettype wire

// File: verilog/icache_top.sv
`timescale 1ns/1ns
`default_nettype none

module icache_top (
    input  logic              Clk,
    input  logic              rst,
    input  logic              read_enable,
    input  icache_pkg::addr_t read_address,
    output icache_pkg::word_t instruction,
    output logic              ready,
    output logic              busy,
    output icache_pkg::addr_t mem_read_address,
    output logic              mem_read_request,
    input  icache_pkg::word_t mem_data_in,
    input  logic              mem_data_ready
);
    import icache_pkg::*;

    // Lookup to tag store
    set_idx_t lookup_set;
    tag_t     lookup_tag;
    logic     hit;
    way_idx_t hit_way;
    way_idx_t victim_way;
    logic     fill_en;
    set_idx_t fill_set;
    way_idx_t fill_way;
    tag_t     fill_tag;

    // Lookup to data store
    set_idx_t rd_set;
    way_idx_t rd_way;
    block_t   rd_block;
    logic     wr_en;
    set_idx_t wr_set;
    way_idx_t wr_way;
    block_t   wr_block;

    // Lookup to refill engine
    logic     refill_start;
    addr_t    refill_address;
    logic     refill_done;
    block_t   refill_block;

    icache_lookup u_lookup (
        .Clk            (Clk),
        .rst            (rst),
        .read_enable    (read_enable),
        .read_address   (read_address),
        .instruction    (instruction),
        .ready          (ready),
        .busy           (busy),
        .lookup_set     (lookup_set),
        .lookup_tag     (lookup_tag),
        .hit            (hit),
        .hit_way        (hit_way),
        .victim_way     (victim_way),
        .fill_en        (fill_en),
        .fill_set       (fill_set),
        .fill_way       (fill_way),
        .fill_tag       (fill_tag),
        .rd_set         (rd_set),
        .rd_way         (rd_way),
        .rd_block       (rd_block),
        .wr_en          (wr_en),
        .wr_set         (wr_set),
        .wr_way         (wr_way),
        .wr_block       (wr_block),
        .refill_start   (refill_start),
        .refill_address (refill_address),
        .refill_done    (refill_done),
        .refill_block   (refill_block)
    );

    icache_tag_store u_tag_store (
        .Clk        (Clk),
        .rst        (rst),
        .lookup_set (lookup_set),
        .lookup_tag (lookup_tag),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .fill_en    (fill_en),
        .fill_set   (fill_set),
        .fill_way   (fill_way),
        .fill_tag   (fill_tag)
    );

    icache_data_store u_data_store (
        .Clk      (Clk),
        .rd_set   (rd_set),
        .rd_way   (rd_way),
        .rd_block (rd_block),
        .wr_en    (wr_en),
        .wr_set   (wr_set),
        .wr_way   (wr_way),
        .wr_block (wr_block)
    );

    icache_refill u_refill (
        .Clk              (Clk),
        .rst              (rst),
        .refill_start     (refill_start),
        .refill_address   (refill_address),
        .refill_done      (refill_done),
        .refill_block     (refill_block),
        .mem_read_address (mem_read_address),
        .mem_read_request (mem_read_request),
        .mem_data_in      (mem_data_in),
        .mem_data_ready   (mem_data_ready)
    );

endmodule

`default_nettype wire
